//--- hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file
`define RV_NREGS 32
`define RV_REG_AW 5

`define RV_RESET_PC 32'h8000_0000

`endif

//--- hw/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;
  // bit n enables byte lane n
  typedef logic [3:0] wmask_t;
  typedef logic [2:0] funct3_t;

  // supported major opcodes
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    AUIPC  = 7'b001_0111,
    LUI    = 7'b011_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011
  } opcode_e;

  // what the execute stage has to do
  typedef enum logic [2:0] {
    OPC_IMM,
    OPC_LUI,
    OPC_AUIPC,
    OPC_JAL,
    OPC_JALR,
    OPC_LOAD,
    OPC_STORE,
    OPC_NONE
  } op_class_e;

  // load/store access size, spec encoding
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // same instruction word seen through each format
  typedef union packed {
    word_t raw;
    struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      funct3_t     funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0]  imm_hi;
      reg_idx_t    rs2;
      reg_idx_t    rs1;
      funct3_t     funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_fmt;
    struct packed {
      logic [19:0] imm;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic        imm_20;
      logic [9:0]  imm_10_1;
      logic        imm_11;
      logic [7:0]  imm_19_12;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } j_fmt;
  } inst_t;

endpackage

//--- hw/rv_ctrl_if.sv
`timescale 1ns/100ps

// decoded control, valid combinationally within the cycle
interface rv_ctrl_if
  import rv_pkg::*;
  ();

  op_class_e op_class;
  // sign extended, U-type already shifted
  word_t     imm;
  funct3_t   funct3;
  reg_idx_t  rd;
  logic      rd_wen;

  modport decode (
    output op_class, imm, funct3, rd, rd_wen
  );

  modport execute (
    input op_class, imm, funct3, rd, rd_wen
  );

endinterface

//--- hw/rv_decode.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_decode
  import rv_pkg::*;
(
  input  inst_t     inst,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  rv_ctrl_if.decode ctrl
);

  opcode_e opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode = opcode_e'(inst.i_fmt.opcode);

  // register indices sit at the same place for every format
  assign rs1 = inst.i_fmt.rs1;
  assign rs2 = inst.s_fmt.rs2;

  assign ctrl.rd     = inst.i_fmt.rd;
  assign ctrl.funct3 = inst.i_fmt.funct3;

  // immediates per format
  assign imm_i = {{(`RV_XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{(`RV_XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi,
                  inst.s_fmt.imm_lo};
  assign imm_u = {inst.u_fmt.imm, 12'h000};
  assign imm_j = {{(`RV_XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
                  inst.j_fmt.imm_19_12, inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    ctrl.op_class = OPC_NONE;
    ctrl.imm      = '0;
    case (opcode)
      OP_IMM: begin
        ctrl.op_class = OPC_IMM;
        ctrl.imm      = imm_i;
      end
      LUI: begin
        ctrl.op_class = OPC_LUI;
        ctrl.imm      = imm_u;
      end
      AUIPC: begin
        ctrl.op_class = OPC_AUIPC;
        ctrl.imm      = imm_u;
      end
      JAL: begin
        ctrl.op_class = OPC_JAL;
        ctrl.imm      = imm_j;
      end
      JALR: begin
        ctrl.op_class = OPC_JALR;
        ctrl.imm      = imm_i;
      end
      LOAD: begin
        ctrl.op_class = OPC_LOAD;
        ctrl.imm      = imm_i;
      end
      STORE: begin
        ctrl.op_class = OPC_STORE;
        ctrl.imm      = imm_s;
      end
      default: ;
    endcase
  end

  // writes to x0 are dropped here
  assign ctrl.rd_wen = (ctrl.op_class != OPC_STORE) && (ctrl.op_class != OPC_NONE) &&
                       (inst.i_fmt.rd != '0);

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  word_t regs [0:`RV_NREGS-1];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (!rst && wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, x0 reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_execute
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  rv_ctrl_if.execute ctrl,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  word_t      mem_rdata,
  output word_t      pc,
  output word_t      mem_addr,
  output word_t      mem_wdata,
  output wmask_t     mem_wmask,
  output logic       mem_read,
  output logic       mem_write,
  output logic       wb_en,
  output word_t      wb_data
);

  word_t    op_a;
  word_t    sum;
  word_t    pc_plus4;
  word_t    next_pc;
  word_t    load_val;
  wmask_t   lane_mask;
  logic [1:0] offs;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // one shared adder for address, jump target and result
  always_comb begin
    case (ctrl.op_class)
      OPC_AUIPC, OPC_JAL: op_a = pc;
      OPC_LUI:            op_a = '0;
      default:            op_a = rs1_data;
    endcase
  end

  assign sum      = op_a + ctrl.imm;
  assign pc_plus4 = pc + 32'd4;
  assign offs     = sum[1:0];

  always_comb begin
    case (ctrl.op_class)
      OPC_JAL:  next_pc = sum;
      OPC_JALR: next_pc = {sum[`RV_XLEN-1:1], 1'b0};
      default:  next_pc = pc_plus4;
    endcase
  end

  // lane picks for loads
  assign ld_byte = mem_rdata[{offs, 3'b000} +: 8];
  assign ld_half = offs[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    load_val = '0;
    case (ctrl.funct3)
      F3_B:  load_val = {{24{ld_byte[7]}}, ld_byte};
      F3_BU: load_val = {24'h0, ld_byte};
      F3_H:  load_val = offs[0] ? '0 : {{16{ld_half[15]}}, ld_half};
      F3_HU: load_val = offs[0] ? '0 : {16'h0, ld_half};
      F3_W:  load_val = (offs == 2'b00) ? mem_rdata : '0;
      default: ;
    endcase
  end

  // store lanes, misaligned accesses get no lanes
  always_comb begin
    lane_mask = '0;
    case (ctrl.funct3)
      F3_B: lane_mask = 4'b0001 << offs;
      F3_H: lane_mask = offs[0] ? 4'b0000 : (4'b0011 << offs);
      F3_W: lane_mask = (offs == 2'b00) ? 4'b1111 : 4'b0000;
      default: ;
    endcase
  end

  assign mem_addr  = sum;
  assign mem_wdata = rs2_data << {offs, 3'b000};
  assign mem_read  = (ctrl.op_class == OPC_LOAD);
  assign mem_write = (ctrl.op_class == OPC_STORE) && !rst;
  assign mem_wmask = mem_write ? lane_mask : 4'b0000;

  // write-back
  assign wb_en = ctrl.rd_wen && !rst;

  always_comb begin
    case (ctrl.op_class)
      OPC_JAL, OPC_JALR: wb_data = pc_plus4;
      OPC_LOAD:          wb_data = load_val;
      default:           wb_data = sum;
    endcase
  end

endmodule

//--- hw/rv_core_top.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core_top
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    inst,
  input  word_t    mem_rdata,
  output word_t    pc,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output wmask_t   mem_wmask,
  output logic     mem_read,
  output logic     mem_write,
  output logic     wb_en,
  output reg_idx_t wb_addr,
  output word_t    wb_data
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;

  rv_ctrl_if ctrl_if ();

  rv_decode i_rv_decode (
    .inst (inst),
    .rs1  (rs1),
    .rs2  (rs2),
    .ctrl (ctrl_if.decode)
  );

  // written back at the retiring edge
  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (ctrl_if.rd_wen),
    .waddr    (ctrl_if.rd),
    .wdata    (wb_data)
  );

  rv_execute i_rv_execute (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl_if.execute),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .wb_en     (wb_en),
    .wb_data   (wb_data)
  );

  assign wb_addr = ctrl_if.rd;

endmodule

//--- verif/rv_core_checker.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core_checker
  import rv_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input word_t    pc,
  input logic     mem_read,
  input logic     mem_write,
  input wmask_t   mem_wmask,
  input logic     wb_en,
  input reg_idx_t wb_addr
);

  // first cycle out of reset fetches from the reset vector
  pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> pc == `RV_RESET_PC)
    else $error("pc is not the reset vector in the first cycle after reset");

  rd_wr_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
    else $error("mem_read and mem_write are high together");

  // no lanes without a write strobe
  mask_needs_write: assert property (@(posedge clk) !mem_write |-> mem_wmask == 4'b0000)
    else $error("mem_wmask is not zero while mem_write is low");

  no_x0_write: assert property (@(posedge clk) wb_en |-> wb_addr != '0)
    else $error("register write enabled for x0");

endmodule

bind rv_core_top rv_core_checker i_rv_core_checker (
  .clk       (clk),
  .rst       (rst),
  .pc        (pc),
  .mem_read  (mem_read),
  .mem_write (mem_write),
  .mem_wmask (mem_wmask),
  .wb_en     (wb_en),
  .wb_addr   (wb_addr)
);

//--- verif/rv_core_tb.sv
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core_tb
  import rv_pkg::*;
();

  typedef struct packed {
    word_t    instr;
    word_t    rdata;
    word_t    pc_after;
    logic     wb_en;
    reg_idx_t wb_addr;
    word_t    wb_data;
    logic     mem_read;
    logic     mem_write;
    word_t    mem_addr;
    wmask_t   mem_wmask;
    word_t    mem_wdata;
  } row_t;

  logic     clk = 1'b0;
  logic     rst;
  word_t    inst;
  word_t    mem_rdata;
  word_t    pc;
  word_t    mem_addr;
  word_t    mem_wdata;
  wmask_t   mem_wmask;
  logic     mem_read;
  logic     mem_write;
  logic     wb_en;
  reg_idx_t wb_addr;
  word_t    wb_data;

  row_t  rows[$];
  row_t  r;
  word_t regs_m [0:`RV_NREGS-1];
  word_t pc_m;
  word_t rng;
  word_t expect_pc;
  int    cycles = 0;

  rv_core_top i_rv_core_top (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 2 * rows.size() + 20) begin
      $display("timeout: the run did not finish within %0d cycles", 2 * rows.size() + 20);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  function automatic word_t xorshift(word_t s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // instruction encoders, RISC-V base formats
  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                  reg_idx_t rd, opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  function automatic word_t load_expect(word_t data, logic [1:0] off, funct3_t f3);
    logic [7:0]  b;
    logic [15:0] h;
    b = data[{off, 3'b000} +: 8];
    h = data[{off[1], 4'b0000} +: 16];
    case (f3)
      F3_B:    return {{24{b[7]}}, b};
      F3_BU:   return {24'h0, b};
      F3_H:    return {{16{h[15]}}, h};
      F3_HU:   return {16'h0, h};
      default: return data;
    endcase
  endfunction

  task automatic new_row(word_t instr);
    r = '0;
    r.instr = instr;
    r.pc_after = pc_m + 32'd4;
  endtask

  // shadow state follows each committed row
  task automatic commit_row();
    if (r.wb_en) begin
      regs_m[r.wb_addr] = r.wb_data;
    end
    pc_m = r.pc_after;
    rows.push_back(r);
  endtask

  task automatic set_wb(reg_idx_t rd, word_t data);
    r.wb_en = (rd != '0);
    r.wb_addr = rd;
    r.wb_data = data;
  endtask

  task automatic do_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    new_row(enc_i(imm, rs1, 3'b000, rd, OP_IMM));
    set_wb(rd, regs_m[rs1] + sext12(imm));
    commit_row();
  endtask

  task automatic do_upper(reg_idx_t rd, logic [19:0] imm, opcode_e op);
    new_row({imm, rd, op});
    set_wb(rd, (op == AUIPC) ? pc_m + {imm, 12'h000} : {imm, 12'h000});
    commit_row();
  endtask

  task automatic do_jal(reg_idx_t rd, logic [20:0] off);
    new_row(enc_j(off, rd));
    set_wb(rd, pc_m + 32'd4);
    r.pc_after = pc_m + {{11{off[20]}}, off};
    commit_row();
  endtask

  task automatic do_jalr(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    word_t target;
    target = regs_m[rs1] + sext12(imm);
    new_row(enc_i(imm, rs1, 3'b000, rd, JALR));
    set_wb(rd, pc_m + 32'd4);
    r.pc_after = {target[31:1], 1'b0};
    commit_row();
  endtask

  task automatic do_load(reg_idx_t rd, logic [11:0] imm, funct3_t f3, word_t data);
    word_t addr;
    addr = regs_m[1] + sext12(imm);
    new_row(enc_i(imm, 5'd1, f3, rd, LOAD));
    r.rdata = data;
    r.mem_read = 1'b1;
    r.mem_addr = addr;
    set_wb(rd, load_expect(data, addr[1:0], f3));
    commit_row();
  endtask

  task automatic do_store(logic [11:0] imm, funct3_t f3);
    word_t addr;
    addr = regs_m[1] + sext12(imm);
    new_row(enc_s(imm, 5'd7, 5'd1, f3));
    r.mem_write = 1'b1;
    r.mem_addr = addr;
    case (f3)
      F3_B:    r.mem_wmask = 4'b0001 << addr[1:0];
      F3_H:    r.mem_wmask = 4'b0011 << addr[1:0];
      default: r.mem_wmask = 4'b1111;
    endcase
    r.mem_wdata = regs_m[7] << {addr[1:0], 3'b000};
    commit_row();
  endtask

  task automatic build_table();
    rng = 32'hb142_2b63;
    pc_m = `RV_RESET_PC;
    for (int i = 0; i < `RV_NREGS; i++) begin
      regs_m[i] = '0;
    end
    // R-type add is not supported, so it only steps pc
    new_row(32'h0000_0033);
    commit_row();
    for (int i = 1; i < 8; i++) begin
      rng = xorshift(rng);
      do_addi(5'(i), 5'd0, rng[11:0]);
    end
    for (int i = 0; i < 12; i++) begin
      rng = xorshift(rng);
      do_addi(5'(rng[2:0]), 5'(rng[5:3]), rng[31:20]);
    end
    do_addi(5'd0, 5'd3, 12'h123);
    do_addi(5'd4, 5'd0, 12'h005);
    do_upper(5'd5, 20'hfedcb, LUI);
    do_upper(5'd6, 20'h00012, AUIPC);
    do_jal(5'd1, 21'h00010);
    do_jal(5'd2, 21'h1f_fff8);
    do_jalr(5'd3, 5'd1, 12'h7f3);
    do_jalr(5'd3, 5'd3, 12'hffd);
    // base address in x1, store data in x7
    do_upper(5'd1, 20'h80001, LUI);
    do_upper(5'd7, 20'hc3a5e, LUI);
    do_addi(5'd7, 5'd7, 12'h6b9);
    for (int off = 0; off < 4; off++) begin
      do_load(5'd6, 12'(off), F3_B, 32'h8f7e_c3a5);
      do_load(5'd6, 12'(off), F3_BU, 32'h8f7e_c3a5);
      do_load(5'd6, 12'(off), F3_B, 32'h7e8f_3c5a);
      do_store(12'(off), F3_B);
    end
    for (int off = 0; off < 4; off += 2) begin
      do_load(5'd6, 12'(off), F3_H, 32'h8f7e_c3a5);
      do_load(5'd6, 12'(off), F3_HU, 32'h8f7e_c3a5);
      do_load(5'd6, 12'(off), F3_H, 32'h7e8f_3c5a);
      do_store(12'(off), F3_H);
    end
    do_load(5'd6, 12'h000, F3_W, 32'h8f7e_c3a5);
    do_store(12'h000, F3_W);
    do_addi(5'd2, 5'd0, 12'h000);
    new_row(32'h0010_0073);
    commit_row();
  endtask

  task automatic stop_on_error();
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_mask(string name, wmask_t got, wmask_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_row(row_t rw, word_t pc_exp);
    check_word("pc", pc, pc_exp);
    check_bit("wb_en", wb_en, rw.wb_en);
    if (rw.wb_en) begin
      check_word("wb_addr", 32'(wb_addr), 32'(rw.wb_addr));
      check_word("wb_data", wb_data, rw.wb_data);
    end
    check_bit("mem_read", mem_read, rw.mem_read);
    check_bit("mem_write", mem_write, rw.mem_write);
    check_mask("mem_wmask", mem_wmask, rw.mem_wmask);
    if (rw.mem_read || rw.mem_write) begin
      check_word("mem_addr", mem_addr, rw.mem_addr);
    end
    if (rw.mem_write) begin
      check_word("mem_wdata", mem_wdata, rw.mem_wdata);
    end
  endtask

  initial begin
    rst = 1'b1;
    inst = '0;
    mem_rdata = '0;
    build_table();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    expect_pc = `RV_RESET_PC;
    // outputs are sampled mid-cycle, before the retiring edge
    foreach (rows[i]) begin
      inst <= rows[i].instr;
      mem_rdata <= rows[i].rdata;
      @(negedge clk);
      check_row(rows[i], expect_pc);
      expect_pc = rows[i].pc_after;
      @(posedge clk);
    end
    @(negedge clk);
    check_word("pc", pc, expect_pc);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- files.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core_top.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim
	./obj_dir/rv_core_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Something failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
